//--- verilog/macPkg.sv
`default_nettype none

package macPkg;

	// 68000 data bus word, also the memory data width
	typedef logic [15:0] cpuWord_t;

	// one VIA register byte
	typedef logic [7:0] viaReg_t;

	// register number, from A12-A9
	typedef logic [3:0] regIndex_t;

	// one enable bit per binary weight x1, x2, x4
	typedef logic [2:0] volume_t;

	// unsigned 8-bit sound sample
	typedef logic [7:0] audioSample_t;

	// sample scaled by up to x7
	typedef logic [10:0] audioLevel_t;

	// output register B, bit 7 is sound off
	localparam regIndex_t regOrb = 4'd0;

	// output register A, volume in 2..0, alt sound in 3, overlay in 4
	localparam regIndex_t regOra = 4'd1;

	// interrupt flag and enable registers
	localparam regIndex_t regIfr = 4'd13;
	localparam regIndex_t regIer = 4'd14;

	// overlay starts on so the ROM is mapped at address zero
	localparam viaReg_t oraResetValue = 8'h10;

	// vertical blank flag position in IFR and IER
	localparam int ifrVblankBit = 1;

endpackage

`default_nettype wire

//--- verilog/cpuBusIf.sv
`default_nettype none

// one decoded peripheral cycle from the 68000 to the VIA registers
interface cpuBusIf;

	// high on every clk8 edge of an active write
	logic writeStrobe;

	macPkg::regIndex_t regIndex;

	// upper data byte, the VIA sits on D15-D8
	macPkg::viaReg_t writeData;

	// selected register, valid combinationally from regIndex
	macPkg::viaReg_t readData;

	modport decoder (
		output writeStrobe,
		output regIndex,
		output writeData,
		input readData
	);

	modport registers (
		input writeStrobe,
		input regIndex,
		input writeData,
		output readData
	);

endinterface

`default_nettype wire

//--- verilog/cpuControl.sv
`default_nettype none

module cpuControl #(
	parameter int resetCycles = 800000
) (
	input wire clk8,
	input wire _systemReset,
	input wire _viaIrq,
	input wire _sccIrq,
	output wire _cpuReset,
	output logic [2:0] _cpuIpl
);

	// wide enough to hold resetCycles itself
	localparam int counterWidth = (resetCycles < 2) ? 1 : $clog2(resetCycles + 1);

	logic [counterWidth-1:0] resetCount;

	// 68000 needs RESET and HALT held for a long time after power-up
	always_ff @(posedge clk8 or negedge _systemReset) begin
		if (!_systemReset) begin
			resetCount <= counterWidth'(resetCycles);
		end else if (resetCount != '0) begin
			resetCount <= resetCount - 1'b1;
		end
	end

	assign _cpuReset = (resetCount == '0);

	// VIA at level 1, SCC at level 2, but VIA wins when both pending
	always_comb begin
		if (!_viaIrq) begin
			_cpuIpl = 3'b110;
		end else if (!_sccIrq) begin
			_cpuIpl = 3'b101;
		end else begin
			_cpuIpl = 3'b111;
		end
	end

	// only the three encodings the interrupt scheme uses
	iplLegal: assert property (
		@(posedge clk8) disable iff (!_systemReset)
		_cpuIpl inside {3'b110, 3'b101, 3'b111}
	);

endmodule

`default_nettype wire

//--- verilog/busDecode.sv
`default_nettype none

module busDecode (
	input wire clk8,
	input wire _cpuReset,
	input wire selectVia,
	input wire _cpuUDS,
	input wire _cpuRW,
	input macPkg::regIndex_t cpuAddrRegHi,
	input macPkg::cpuWord_t cpuDataIn,
	input macPkg::cpuWord_t memoryDataIn,
	output macPkg::cpuWord_t cpuDataOut,
	cpuBusIf.decoder bus
);

	logic viaActive;

	// the VIA only answers on the upper data strobe
	assign viaActive = selectVia && !_cpuUDS;

	assign bus.writeStrobe = viaActive && !_cpuRW;

	assign bus.regIndex = cpuAddrRegHi;

	// register byte is on D15-D8
	assign bus.writeData = cpuDataIn[15:8];

	// lower byte floats high on a real VIA read
	always_comb begin
		if (selectVia) begin
			cpuDataOut = {bus.readData, 8'hFF};
		end else begin
			cpuDataOut = memoryDataIn;
		end
	end

	// a read cycle must never reach the register file as a write
	noWriteOnRead: assert property (
		@(posedge clk8) disable iff (!_cpuReset)
		bus.writeStrobe |-> !_cpuRW
	);

endmodule

`default_nettype wire

//--- verilog/viaRegisters.sv
`default_nettype none

module viaRegisters (
	input wire clk8,
	input wire _cpuReset,
	input wire _vblank,
	cpuBusIf.registers bus,
	output macPkg::volume_t volume,
	output wire altSound,
	output wire soundOff,
	output wire memoryOverlayOn,
	output wire _viaIrq
);

	macPkg::viaReg_t ora;
	macPkg::viaReg_t orb;
	logic [6:0] ifr;
	logic [6:0] ier;
	logic [6:0] ifrNext;
	logic vblankPrev;
	logic vblankFall;
	logic irqActive;

	// falling edge of blanking, registered once
	always_ff @(posedge clk8 or negedge _cpuReset) begin
		if (!_cpuReset) begin
			vblankPrev <= 1'b1;
			vblankFall <= 1'b0;
		end else begin
			vblankPrev <= _vblank;
			vblankFall <= vblankPrev && !_vblank;
		end
	end

	// a new vblank event wins over a clear in the same cycle
	always_comb begin
		ifrNext = ifr;
		if (bus.writeStrobe && bus.regIndex == macPkg::regIfr) begin
			ifrNext = ifr & ~bus.writeData[6:0];
		end
		if (vblankFall) begin
			ifrNext[macPkg::ifrVblankBit] = 1'b1;
		end
	end

	always_ff @(posedge clk8 or negedge _cpuReset) begin
		if (!_cpuReset) begin
			ora <= macPkg::oraResetValue;
			orb <= '0;
			ifr <= '0;
			ier <= '0;
		end else begin
			ifr <= ifrNext;
			if (bus.writeStrobe) begin
				case (bus.regIndex)
					macPkg::regOrb: orb <= bus.writeData;
					macPkg::regOra: ora <= bus.writeData;
					macPkg::regIer: begin
						// bit 7 picks set or clear for the other bits
						if (bus.writeData[7]) begin
							ier <= ier | bus.writeData[6:0];
						end else begin
							ier <= ier & ~bus.writeData[6:0];
						end
					end
					default: ;
				endcase
			end
		end
	end

	assign irqActive = |(ifr & ier);
	assign _viaIrq = !irqActive;

	always_comb begin
		case (bus.regIndex)
			macPkg::regOrb: bus.readData = orb;
			macPkg::regOra: bus.readData = ora;
			macPkg::regIfr: bus.readData = {irqActive, ifr};
			// bit 7 reads as one, as on the 6522
			macPkg::regIer: bus.readData = {1'b1, ier};
			default: bus.readData = 8'hFF;
		endcase
	end

	assign volume = ora[2:0];
	assign altSound = ora[3];
	assign memoryOverlayOn = ora[4];
	assign soundOff = orb[7];

	irqHasSource: assert property (
		@(posedge clk8) disable iff (!_cpuReset)
		!_viaIrq |-> (ifr & ier) != '0
	);

endmodule

`default_nettype wire

//--- verilog/audioOutput.sv
`default_nettype none

module audioOutput (
	input wire clk8,
	input wire _cpuReset,
	input wire loadSound,
	input wire soundOff,
	input macPkg::volume_t volume,
	input macPkg::cpuWord_t memoryDataIn,
	output macPkg::audioLevel_t audioOut
);

	logic loadSoundD;
	macPkg::audioSample_t audioLatch;
	macPkg::audioLevel_t audioX1;
	macPkg::audioLevel_t audioX2;
	macPkg::audioLevel_t audioX4;

	// sample word arrives on the memory bus one cycle after the load request
	always_ff @(posedge clk8 or negedge _cpuReset) begin
		if (!_cpuReset) begin
			loadSoundD <= 1'b0;
		end else begin
			loadSoundD <= loadSound;
		end
	end

	// 8'h80 is the midpoint, silence for unsigned samples
	always_ff @(posedge clk8 or negedge _cpuReset) begin
		if (!_cpuReset) begin
			audioLatch <= '0;
		end else if (loadSoundD) begin
			if (soundOff) begin
				audioLatch <= 8'h80;
			end else begin
				audioLatch <= memoryDataIn[15:8];
			end
		end
	end

	// x1, x2 and x4 copies of the sample
	assign audioX1 = {3'b000, audioLatch};
	assign audioX2 = {2'b00, audioLatch, 1'b0};
	assign audioX4 = {1'b0, audioLatch, 2'b00};

	// max is 255 * 7, fits in 11 bits
	assign audioOut = (volume[0] ? audioX1 : 11'd0)
		+ (volume[1] ? audioX2 : 11'd0)
		+ (volume[2] ? audioX4 : 11'd0);

endmodule

`default_nettype wire

//--- verilog/dataControllerTop.sv
`default_nettype none

module dataControllerTop #(
	parameter int resetCycles = 800000
) (
	input wire clk8,
	input wire _systemReset,
	input wire selectVia,
	input wire _cpuUDS,
	input wire _cpuRW,
	input macPkg::regIndex_t cpuAddrRegHi,
	input macPkg::cpuWord_t cpuDataIn,
	input macPkg::cpuWord_t memoryDataIn,
	input wire _vblank,
	input wire _sccIrq,
	input wire loadSound,
	output macPkg::cpuWord_t cpuDataOut,
	output wire _cpuReset,
	output wire [2:0] _cpuIpl,
	output wire memoryOverlayOn,
	output wire altSound,
	output macPkg::audioLevel_t audioOut
);

	wire _viaIrq;
	wire soundOff;
	wire macPkg::volume_t volume;

	cpuBusIf viaBus();

	cpuControl #(
		.resetCycles(resetCycles)
	) control (
		.clk8(clk8),
		._systemReset(_systemReset),
		._viaIrq(_viaIrq),
		._sccIrq(_sccIrq),
		._cpuReset(_cpuReset),
		._cpuIpl(_cpuIpl)
	);

	busDecode decode (
		.clk8(clk8),
		._cpuReset(_cpuReset),
		.selectVia(selectVia),
		._cpuUDS(_cpuUDS),
		._cpuRW(_cpuRW),
		.cpuAddrRegHi(cpuAddrRegHi),
		.cpuDataIn(cpuDataIn),
		.memoryDataIn(memoryDataIn),
		.cpuDataOut(cpuDataOut),
		.bus(viaBus.decoder)
	);

	viaRegisters via (
		.clk8(clk8),
		._cpuReset(_cpuReset),
		._vblank(_vblank),
		.bus(viaBus.registers),
		.volume(volume),
		.altSound(altSound),
		.soundOff(soundOff),
		.memoryOverlayOn(memoryOverlayOn),
		._viaIrq(_viaIrq)
	);

	audioOutput audio (
		.clk8(clk8),
		._cpuReset(_cpuReset),
		.loadSound(loadSound),
		.soundOff(soundOff),
		.volume(volume),
		.memoryDataIn(memoryDataIn),
		.audioOut(audioOut)
	);

endmodule

`default_nettype wire

//--- verif/dataControllerChecker.sv
`default_nettype none

module dataControllerChecker #(
	parameter int resetCycles = 64
) (
	input wire clk8,
	input wire _systemReset,
	input wire selectVia,
	input wire _cpuUDS,
	input wire _cpuRW,
	input macPkg::regIndex_t cpuAddrRegHi,
	input macPkg::cpuWord_t cpuDataIn,
	input macPkg::cpuWord_t memoryDataIn,
	input wire _vblank,
	input wire _sccIrq,
	input wire loadSound,
	input macPkg::cpuWord_t cpuDataOut,
	input wire _cpuReset,
	input wire [2:0] _cpuIpl,
	input wire memoryOverlayOn,
	input wire altSound,
	input macPkg::audioLevel_t audioOut,
	output int errorCount,
	output int checkCount
);

	// model state, as it stands after the last rising edge
	int resetCount = resetCycles;
	int lowCycles = 0;
	logic releaseSeen = 1'b0;
	macPkg::viaReg_t ora = macPkg::oraResetValue;
	macPkg::viaReg_t orb = '0;
	logic [6:0] ifr = '0;
	logic [6:0] ier = '0;
	logic vblankPrev = 1'b1;
	logic vblankFall = 1'b0;
	logic loadDelay = 1'b0;
	macPkg::audioSample_t sample = '0;

	initial begin
		errorCount = 0;
		checkCount = 0;
	end

	function automatic macPkg::viaReg_t viaReadback(input macPkg::regIndex_t index);
		case (index)
			macPkg::regOrb: return orb;
			macPkg::regOra: return ora;
			macPkg::regIfr: return {|(ifr & ier), ifr};
			// 6522 returns ones in IER bit 7
			macPkg::regIer: return {1'b1, ier};
			default: return 8'hFF;
		endcase
	endfunction

	task automatic compareValue(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("** Error at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	// inputs settle after the rising edge, so sample on the falling one
	always @(negedge clk8) begin
		logic [2:0] iplExpected;
		logic [6:0] ifrNext;
		logic writeNow;
		logic inReset;
		if (|(ifr & ier)) begin
			iplExpected = 3'b110;
		end else if (!_sccIrq) begin
			iplExpected = 3'b101;
		end else begin
			iplExpected = 3'b111;
		end
		compareValue("_cpuReset", _cpuReset, resetCount == 0);
		compareValue("cpuDataOut", cpuDataOut,
			selectVia ? {viaReadback(cpuAddrRegHi), 8'hFF} : memoryDataIn);
		compareValue("_cpuIpl", _cpuIpl, iplExpected);
		compareValue("memoryOverlayOn", memoryOverlayOn, ora[4]);
		compareValue("altSound", altSound, ora[3]);
		// gated x1, x2, x4 weights add up to sample times volume
		compareValue("audioOut", audioOut, sample * ora[2:0]);

		// length of the reset stretch, counted from release
		if (!_systemReset) begin
			lowCycles = 0;
			releaseSeen = 1'b0;
		end else if (!_cpuReset) begin
			lowCycles++;
		end else if (!releaseSeen) begin
			releaseSeen = 1'b1;
			compareValue("cpu reset length", lowCycles, resetCycles);
		end

		// state at the coming rising edge
		inReset = (resetCount != 0);
		if (inReset) begin
			ora = macPkg::oraResetValue;
			orb = '0;
			ifr = '0;
			ier = '0;
			vblankPrev = 1'b1;
			vblankFall = 1'b0;
			loadDelay = 1'b0;
			sample = '0;
		end else begin
			writeNow = selectVia && !_cpuUDS && !_cpuRW;
			ifrNext = ifr;
			if (writeNow && cpuAddrRegHi == macPkg::regIfr) begin
				ifrNext = ifr & ~cpuDataIn[14:8];
			end
			if (vblankFall) begin
				ifrNext[macPkg::ifrVblankBit] = 1'b1;
			end
			// sound off as it was before this edge's write
			if (loadDelay) begin
				sample = orb[7] ? 8'h80 : memoryDataIn[15:8];
			end
			if (writeNow) begin
				case (cpuAddrRegHi)
					macPkg::regOrb: orb = cpuDataIn[15:8];
					macPkg::regOra: ora = cpuDataIn[15:8];
					macPkg::regIer: ier = cpuDataIn[15] ? (ier | cpuDataIn[14:8])
						: (ier & ~cpuDataIn[14:8]);
					default: ;
				endcase
			end
			ifr = ifrNext;
			vblankFall = vblankPrev && !_vblank;
			vblankPrev = _vblank;
			loadDelay = loadSound;
		end

		if (!_systemReset) begin
			resetCount = resetCycles;
		end else if (resetCount != 0) begin
			resetCount--;
		end
	end

endmodule

`default_nettype wire

//--- verif/dataControllerTb.sv
`default_nettype none

module dataControllerTb;

	localparam int resetCycles = 64;
	localparam int resetHold = 10;
	localparam int testCycles = 3000;
	localparam int watchdogTime = (resetHold + resetCycles + testCycles + 100) * 4;

	logic clk8 = 1'b0;
	logic _systemReset;
	logic selectVia;
	logic _cpuUDS;
	logic _cpuRW;
	macPkg::regIndex_t cpuAddrRegHi;
	macPkg::cpuWord_t cpuDataIn;
	macPkg::cpuWord_t memoryDataIn;
	logic _vblank;
	logic _sccIrq;
	logic loadSound;

	macPkg::cpuWord_t cpuDataOut;
	logic _cpuReset;
	logic [2:0] _cpuIpl;
	logic memoryOverlayOn;
	logic altSound;
	macPkg::audioLevel_t audioOut;

	int errorCount;
	int checkCount;
	logic [31:0] lfsrState = 32'h5fd5;

	always #2 clk8 = ~clk8;

	dataControllerTop #(
		.resetCycles(resetCycles)
	) DUT (
		.clk8(clk8),
		._systemReset(_systemReset),
		.selectVia(selectVia),
		._cpuUDS(_cpuUDS),
		._cpuRW(_cpuRW),
		.cpuAddrRegHi(cpuAddrRegHi),
		.cpuDataIn(cpuDataIn),
		.memoryDataIn(memoryDataIn),
		._vblank(_vblank),
		._sccIrq(_sccIrq),
		.loadSound(loadSound),
		.cpuDataOut(cpuDataOut),
		._cpuReset(_cpuReset),
		._cpuIpl(_cpuIpl),
		.memoryOverlayOn(memoryOverlayOn),
		.altSound(altSound),
		.audioOut(audioOut)
	);

	dataControllerChecker #(
		.resetCycles(resetCycles)
	) outputChecker (
		.clk8(clk8),
		._systemReset(_systemReset),
		.selectVia(selectVia),
		._cpuUDS(_cpuUDS),
		._cpuRW(_cpuRW),
		.cpuAddrRegHi(cpuAddrRegHi),
		.cpuDataIn(cpuDataIn),
		.memoryDataIn(memoryDataIn),
		._vblank(_vblank),
		._sccIrq(_sccIrq),
		.loadSound(loadSound),
		.cpuDataOut(cpuDataOut),
		._cpuReset(_cpuReset),
		._cpuIpl(_cpuIpl),
		.memoryOverlayOn(memoryOverlayOn),
		.altSound(altSound),
		.audioOut(audioOut),
		.errorCount(errorCount),
		.checkCount(checkCount)
	);

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] stepLfsr(input logic [31:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 32'h80200003;
		end
		return state >> 1;
	endfunction

	// one lfsr step per bit taken
	task automatic drawBits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = stepLfsr(lfsrState);
			value = {value[30:0], lfsrState[0]};
		end
	endtask

	task automatic driveRandomCycle();
		logic [31:0] bits;
		logic [31:0] pick;
		drawBits(2, bits);
		selectVia <= (bits[1:0] != 2'b00);
		drawBits(1, bits);
		_cpuRW <= bits[0];
		drawBits(2, bits);
		_cpuUDS <= (bits[1:0] == 2'b00);
		// mapped registers most of the time
		drawBits(1, bits);
		drawBits(4, pick);
		if (bits[0]) begin
			case (pick[1:0])
				2'd0: cpuAddrRegHi <= macPkg::regOrb;
				2'd1: cpuAddrRegHi <= macPkg::regOra;
				2'd2: cpuAddrRegHi <= macPkg::regIfr;
				default: cpuAddrRegHi <= macPkg::regIer;
			endcase
		end else begin
			cpuAddrRegHi <= pick[3:0];
		end
		drawBits(16, bits);
		cpuDataIn <= bits[15:0];
		drawBits(16, bits);
		memoryDataIn <= bits[15:0];
		// short blanking pulses, rare
		drawBits(5, bits);
		_vblank <= (bits[4:0] != 5'd0);
		drawBits(3, bits);
		_sccIrq <= (bits[2:0] != 3'd0);
		drawBits(2, bits);
		loadSound <= (bits[1:0] == 2'b00);
	endtask

	initial begin
		_systemReset = 1'b0;
		selectVia = 1'b0;
		_cpuUDS = 1'b1;
		_cpuRW = 1'b1;
		cpuAddrRegHi = '0;
		cpuDataIn = '0;
		memoryDataIn = '0;
		_vblank = 1'b1;
		_sccIrq = 1'b1;
		loadSound = 1'b0;
		// random cycles run during the reset stretch as well
		for (int cycle = 0; cycle < resetHold + resetCycles + testCycles; cycle++) begin
			@(posedge clk8);
			if (cycle == resetHold) begin
				_systemReset <= 1'b1;
			end
			driveRandomCycle();
		end
		repeat (2) @(posedge clk8);
		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		#(watchdogTime);
		$display("Timeout: the test did not finish within %0d time units", watchdogTime);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
verilog/macPkg.sv
verilog/cpuBusIf.sv
verilog/cpuControl.sv
verilog/busDecode.sv
verilog/viaRegisters.sv
verilog/audioOutput.sv
verilog/dataControllerTop.sv
verif/dataControllerChecker.sv
verif/dataControllerTb.sv

//--- Bender.yml
package:
  name: data_controller

sources:
  - verilog/macPkg.sv
  - verilog/cpuBusIf.sv
  - verilog/cpuControl.sv
  - verilog/busDecode.sv
  - verilog/viaRegisters.sv
  - verilog/audioOutput.sv
  - verilog/dataControllerTop.sv
  - target: simulation
    files:
      - verif/dataControllerChecker.sv
      - verif/dataControllerTb.sv
